// File: verilog/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and sizes
    ////////////////////////////////////////////////////////////

    localparam int XLEN         = 32;
    // Lanes fetched and decoded per cycle
    localparam int FETCH_WIDTH  = 3;
    localparam int FETCH_BYTES  = FETCH_WIDTH * 4;
    // Queue depth, a power of two so pointers wrap on their own
    localparam int BUFFER_DEPTH = 8;
    localparam int PTR_W        = $clog2(BUFFER_DEPTH);
    // Occupancy counts 0 to BUFFER_DEPTH inclusive
    localparam int OCC_W        = $clog2(BUFFER_DEPTH + 1);
    // Lane count per cycle, 0 to FETCH_WIDTH
    localparam int CNT_W        = $clog2(FETCH_WIDTH + 1);
    // Two-bit counter table, indexed by PC word address
    localparam int BHT_ENTRIES  = 64;
    localparam int BHT_IDX_W    = $clog2(BHT_ENTRIES);

    ////////////////////////////////////////////////////////////
    // Opcodes seen by the pre-decode
    ////////////////////////////////////////////////////////////

    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OTHER  = 7'b0000000
    } opcode_e;

    // One fetched lane after pre-decode
    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic            is_branch;
    } fetch_slot_t;

    // Lane 0 is the oldest
    typedef struct packed {
        fetch_slot_t [FETCH_WIDTH-1:0] slot;
        logic [FETCH_WIDTH-1:0]        valid;
    } fetch_group_t;

    // Registered predictor result, aligned with fetch_group_t
    typedef struct packed {
        logic [FETCH_WIDTH-1:0] taken;
    } pred_group_t;

    // Queue element and decode lane payload
    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic            pred;
    } buffer_entry_t;

    // Resolve port from execute
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            taken;
    } bp_update_t;

endpackage

// File: verilog/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic [FETCH_WIDTH-1:0][XLEN-1:0]  lookup_pc_i,
    input  logic                              advance_i,
    input  bp_update_t                        update_i,
    output logic [FETCH_WIDTH-1:0]            taken_o,
    output pred_group_t                       pred_o
);

    // Two-bit saturating counters, 0 and 1 not taken, 2 and 3 taken
    logic [1:0] bht [BHT_ENTRIES];

    logic [FETCH_WIDTH-1:0][BHT_IDX_W-1:0] lookup_idx;
    logic [BHT_IDX_W-1:0]                  update_idx;

    // Word address bits above the byte offset
    function automatic logic [BHT_IDX_W-1:0] bht_index(input logic [XLEN-1:0] pc);
        return pc[BHT_IDX_W+1:2];
    endfunction

    ////////////////////////////////////////////////////////////
    // Lookup, three ports read in parallel
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            lookup_idx[k] = bht_index(lookup_pc_i[k]);
            // Upper bit gives the direction
            taken_o[k]    = bht[lookup_idx[k]][1];
        end
    end

    assign update_idx = bht_index(update_i.pc);

    ////////////////////////////////////////////////////////////
    // Training from the resolve port
    ////////////////////////////////////////////////////////////

    // Same-index lookup in this cycle still reads the old count
    always_ff @(posedge clk) begin
        if (rst_i) begin
            // Weakly not taken
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                bht[i] <= 2'b01;
            end
        end else if (update_i.valid) begin
            if (update_i.taken && bht[update_idx] != 2'b11)
                bht[update_idx] <= bht[update_idx] + 2'b01;
            else if (!update_i.taken && bht[update_idx] != 2'b00)
                bht[update_idx] <= bht[update_idx] - 2'b01;
        end
    end

    // Captured on the same edge as the fetch group register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pred_o <= '0;
        end else if (advance_i) begin
            pred_o.taken <= taken_o;
        end
    end

endmodule

// File: verilog/multi_fetch.sv
`timescale 1ns/1ps

module multi_fetch import fetch_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              flush_i,
    input  logic [XLEN-1:0]                   correct_pc_i,
    output logic [FETCH_WIDTH-1:0][XLEN-1:0]  inst_addr_o,
    input  logic [FETCH_WIDTH-1:0][XLEN-1:0]  instr_i,
    input  logic [FETCH_WIDTH-1:0]            taken_i,
    input  logic                              fetch_ready_i,
    output logic                              advance_o,
    output fetch_group_t                      group_o
);

    logic [XLEN-1:0]               pc_q;
    logic [XLEN-1:0]               next_pc;
    fetch_slot_t [FETCH_WIDTH-1:0] slot;
    opcode_e                       op [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0]        mask;

    // Held group, payload and mask kept apart
    fetch_slot_t [FETCH_WIDTH-1:0] slot_q;
    logic [FETCH_WIDTH-1:0]        valid_q;

    // Major opcode classes
    function automatic opcode_e decode_op(input logic [6:0] bits);
        case (bits)
            OP_BRANCH: return OP_BRANCH;
            OP_JAL:    return OP_JAL;
            OP_JALR:   return OP_JALR;
            default:   return OP_OTHER;
        endcase
    endfunction

    // Immediate for the direct control transfers
    function automatic logic [XLEN-1:0] pre_imm(input logic [XLEN-1:0] i, input opcode_e o);
        case (o)
            // B-type
            OP_BRANCH: return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
            // J-type
            OP_JAL:    return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
            // JALR target depends on rs1, left to execute
            default:   return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Addresses and pre-decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            inst_addr_o[k]     = pc_q + XLEN'(4 * k);
            op[k]              = decode_op(instr_i[k][6:0]);
            slot[k].instr      = instr_i[k];
            slot[k].pc         = inst_addr_o[k];
            slot[k].imm        = pre_imm(instr_i[k], op[k]);
            slot[k].is_branch  = (op[k] == OP_BRANCH);
        end
    end

    // Keep lanes through the first predicted-taken branch
    always_comb begin
        logic hit;
        hit     = 1'b0;
        mask    = '0;
        next_pc = pc_q + XLEN'(FETCH_BYTES);
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            mask[k] = !hit;
            if (!hit && slot[k].is_branch && taken_i[k]) begin
                hit     = 1'b1;
                next_pc = slot[k].pc + slot[k].imm;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // PC and group register
    ////////////////////////////////////////////////////////////

    // Move on when the buffer takes the group or nothing is held
    assign advance_o = flush_i | fetch_ready_i | ~|valid_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q    <= '0;
            valid_q <= '0;
        end else if (flush_i) begin
            // Redirect, drop the group in flight
            pc_q    <= correct_pc_i;
            valid_q <= '0;
        end else if (advance_o) begin
            pc_q    <= next_pc;
            valid_q <= mask;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o)
            slot_q <= slot;
    end

    assign group_o.slot  = slot_q;
    assign group_o.valid = valid_q;

endmodule

// File: verilog/instruction_buffer.sv
`timescale 1ns/1ps

module instruction_buffer import fetch_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_i,
    input  logic                               flush_i,
    input  fetch_group_t                       group_i,
    input  pred_group_t                        pred_i,
    output logic                               fetch_ready_o,
    output buffer_entry_t [FETCH_WIDTH-1:0]    decode_entries_o,
    output logic [FETCH_WIDTH-1:0]             decode_valid_o,
    input  logic [FETCH_WIDTH-1:0]             decode_ready_i,
    output logic                               buffer_empty_o,
    output logic                               buffer_full_o,
    output logic [OCC_W-1:0]                   occupancy_o
);

    buffer_entry_t mem [BUFFER_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [OCC_W-1:0] count;

    buffer_entry_t [FETCH_WIDTH-1:0]     in_entry;
    logic [FETCH_WIDTH-1:0][PTR_W-1:0]   wr_idx;
    logic [FETCH_WIDTH-1:0][PTR_W-1:0]   rd_idx;
    logic [FETCH_WIDTH-1:0]              accept;
    logic [CNT_W-1:0]                    push_n;
    logic [CNT_W-1:0]                    pop_n;
    logic                                push;

    ////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////

    // Room for a whole group
    assign fetch_ready_o = (OCC_W'(BUFFER_DEPTH) - count) >= OCC_W'(FETCH_WIDTH);
    assign push          = fetch_ready_o & |group_i.valid;

    // Merge prediction, pack valid lanes behind the write pointer
    always_comb begin
        push_n = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            in_entry[k].instr = group_i.slot[k].instr;
            in_entry[k].pc    = group_i.slot[k].pc;
            in_entry[k].imm   = group_i.slot[k].imm;
            // Only conditional branches carry a prediction
            in_entry[k].pred  = group_i.slot[k].is_branch & pred_i.taken[k];
            wr_idx[k]         = wr_ptr + PTR_W'(push_n);
            if (group_i.valid[k])
                push_n = push_n + CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            for (int k = 0; k < FETCH_WIDTH; k++) begin
                if (group_i.valid[k])
                    mem[wr_idx[k]] <= in_entry[k];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////

    // Oldest entries on lane 0 upward
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            rd_idx[k]           = rd_ptr + PTR_W'(k);
            decode_entries_o[k] = mem[rd_idx[k]];
            decode_valid_o[k]   = count > OCC_W'(k);
        end
    end

    // In-order prefix, a stalled lane blocks all later ones
    always_comb begin
        logic chain;
        chain = 1'b1;
        pop_n = '0;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            accept[k] = chain & decode_valid_o[k] & decode_ready_i[k];
            chain     = accept[k];
            if (accept[k])
                pop_n = pop_n + CNT_W'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + PTR_W'(push_n);
            rd_ptr <= rd_ptr + PTR_W'(pop_n);
            // Push and pop land on the same edge
            count  <= count + (push ? OCC_W'(push_n) : OCC_W'(0)) - OCC_W'(pop_n);
        end
    end

    assign buffer_empty_o = (count == '0);
    assign buffer_full_o  = (count == OCC_W'(BUFFER_DEPTH));
    assign occupancy_o    = count;

endmodule

// File: verilog/fetch_buffer_top.sv
`timescale 1ns/1ps

module fetch_buffer_top import fetch_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              flush_i,
    input  logic [XLEN-1:0]                   correct_pc_i,
    // Instruction memory, read in the same cycle
    output logic [FETCH_WIDTH-1:0][XLEN-1:0]  inst_addr_o,
    input  logic [FETCH_WIDTH-1:0][XLEN-1:0]  instr_i,
    // Resolve port
    input  bp_update_t                        bp_update_i,
    // Decode lanes
    output buffer_entry_t [FETCH_WIDTH-1:0]   decode_entries_o,
    output logic [FETCH_WIDTH-1:0]            decode_valid_o,
    input  logic [FETCH_WIDTH-1:0]            decode_ready_i,
    // Status
    output logic                              buffer_empty_o,
    output logic                              buffer_full_o,
    output logic [OCC_W-1:0]                  occupancy_o
);

    logic [FETCH_WIDTH-1:0] taken;
    logic                   advance;
    logic                   fetch_ready;
    fetch_group_t           fetch_group;
    pred_group_t            pred_group;

    // PC, memory addresses, pre-decode
    multi_fetch u_fetch (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .correct_pc_i  (correct_pc_i),
        .inst_addr_o   (inst_addr_o),
        .instr_i       (instr_i),
        .taken_i       (taken),
        .fetch_ready_i (fetch_ready),
        .advance_o     (advance),
        .group_o       (fetch_group)
    );

    // Looks up the same three addresses
    branch_predictor u_bpred (
        .clk         (clk),
        .rst_i       (rst_i),
        .lookup_pc_i (inst_addr_o),
        .advance_i   (advance),
        .update_i    (bp_update_i),
        .taken_o     (taken),
        .pred_o      (pred_group)
    );

    // Joins both registered groups
    instruction_buffer u_buffer (
        .clk              (clk),
        .rst_i            (rst_i),
        .flush_i          (flush_i),
        .group_i          (fetch_group),
        .pred_i           (pred_group),
        .fetch_ready_o    (fetch_ready),
        .decode_entries_o (decode_entries_o),
        .decode_valid_o   (decode_valid_o),
        .decode_ready_i   (decode_ready_i),
        .buffer_empty_o   (buffer_empty_o),
        .buffer_full_o    (buffer_full_o),
        .occupancy_o      (occupancy_o)
    );

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o
);

    // Half of the 40 ns period
    localparam int HALF_PERIOD = 20;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule

// File: test/fetch_buffer_checker.sv
`timescale 1ns/1ps

module fetch_buffer_checker import fetch_pkg::*; #(
    parameter int MEM_WORDS = 64
) (
    input logic                               clk,
    input logic                               rst_i,
    input logic                               flush_i,
    input logic [XLEN-1:0]                    correct_pc_i,
    input buffer_entry_t [FETCH_WIDTH-1:0]    entries_i,
    input logic [FETCH_WIDTH-1:0]             valid_i,
    input logic [FETCH_WIDTH-1:0]             ready_i,
    input logic                               empty_i,
    input logic                               full_i,
    input logic [OCC_W-1:0]                   occ_i,
    input logic [MEM_WORDS-1:0][XLEN-1:0]     mem_i
);

    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Read by the testbench
    int fail_count = 0;

    logic [XLEN-1:0]                  exp_q;
    logic [XLEN-1:0]                  next_exp;
    logic [FETCH_WIDTH-1:0]           acc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] exp_pc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] exp_imm;

    // Immediate straight from the ISA encoding
    function automatic logic [XLEN-1:0] field_imm(input logic [XLEN-1:0] w);
        case (w[6:0])
            // Conditional branch, B-type
            7'b1100011: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            // JAL, J-type
            7'b1101111: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:    return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference PC stream
    ////////////////////////////////////////////////////////////

    // Accepted prefix and the PC each lane should carry
    always_comb begin
        logic chain;
        chain    = 1'b1;
        next_exp = exp_q;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            acc[k]     = chain & valid_i[k] & ready_i[k];
            chain      = acc[k];
            exp_pc[k]  = next_exp;
            exp_imm[k] = field_imm(entries_i[k].instr);
            // Predicted taken jumps by its offset, else falls through
            if (acc[k])
                next_exp = entries_i[k].pred ? next_exp + exp_imm[k] : next_exp + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i)
            exp_q <= '0;
        else if (flush_i)
            exp_q <= correct_pc_i;
        else
            exp_q <= next_exp;
    end

    ////////////////////////////////////////////////////////////
    // Per-lane decode checks
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_lane
        a_pc_order: assert property (@(posedge clk) disable iff (rst_i || flush_i)
            acc[k] |-> entries_i[k].pc == exp_pc[k])
            else begin
                $error("FAILED at %0t ns: lane %0d PC %h, expected %h",
                       $time, k, entries_i[k].pc, exp_pc[k]);
                fail_count++;
            end
        a_instr: assert property (@(posedge clk) disable iff (rst_i || flush_i)
            acc[k] |-> entries_i[k].instr == mem_i[entries_i[k].pc[MEM_IDX_W+1:2]])
            else begin
                $error("FAILED at %0t ns: lane %0d word %h does not match memory",
                       $time, k, entries_i[k].instr);
                fail_count++;
            end
        a_imm: assert property (@(posedge clk) disable iff (rst_i || flush_i)
            acc[k] |-> entries_i[k].imm == exp_imm[k])
            else begin
                $error("FAILED at %0t ns: lane %0d immediate %h, expected %h",
                       $time, k, entries_i[k].imm, exp_imm[k]);
                fail_count++;
            end
    end

    ////////////////////////////////////////////////////////////
    // Flush and status flags
    ////////////////////////////////////////////////////////////

    a_flush_clears: assert property (@(posedge clk) disable iff (rst_i)
        flush_i |=> (occ_i == '0 && empty_i && valid_i == '0))
        else begin
            $error("Buffer not cleared one cycle after flush");
            fail_count++;
        end

    a_occ_bound: assert property (@(posedge clk) disable iff (rst_i)
        occ_i <= OCC_W'(BUFFER_DEPTH))
        else begin
            $error("Occupancy %0d above depth", occ_i);
            fail_count++;
        end

    a_full_flag: assert property (@(posedge clk) disable iff (rst_i)
        full_i == (occ_i == OCC_W'(BUFFER_DEPTH)))
        else begin
            $error("Full flag disagrees with occupancy %0d", occ_i);
            fail_count++;
        end

    a_empty_flag: assert property (@(posedge clk) disable iff (rst_i)
        empty_i == (occ_i == '0))
        else begin
            $error("Empty flag disagrees with occupancy %0d", occ_i);
            fail_count++;
        end

endmodule

// File: test/fetch_buffer_tb.sv
`timescale 1ns/1ps

module fetch_buffer_tb import fetch_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int MEM_WORDS    = 64;
    localparam int MEM_IDX_W    = $clog2(MEM_WORDS);
    // Phase lengths in cycles
    localparam int WARM_CYCLES  = 80;
    localparam int FILL_CYCLES  = 12;
    localparam int TOPUP_CYCLES = 6;
    localparam int TRAIN_LIMIT  = 60;
    localparam int TAIL_CYCLES  = 30;
    // Sum of all phases plus slack
    localparam int TOTAL_CYCLES = 2 + WARM_CYCLES + FILL_CYCLES + TOPUP_CYCLES
                                  + WARM_CYCLES / 2 + TRAIN_LIMIT + TAIL_CYCLES + 20;
    // Trained branch jumps back 32 bytes
    localparam logic [XLEN-1:0] BR_PC     = 32'h0000_00A0;
    localparam logic [XLEN-1:0] BR_TARGET = 32'h0000_0080;
    localparam logic [XLEN-1:0] FLUSH_PC  = BR_PC - 32'd8;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP       = 32'h0000_0013;

    logic                             clk;
    logic                             rst;
    logic                             flush;
    logic [XLEN-1:0]                  correct_pc;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] inst_addr;
    logic [FETCH_WIDTH-1:0][XLEN-1:0] instr;
    bp_update_t                       bp_update;
    buffer_entry_t [FETCH_WIDTH-1:0]  dec_entries;
    logic [FETCH_WIDTH-1:0]           dec_valid;
    logic [FETCH_WIDTH-1:0]           dec_ready;
    logic                             empty;
    logic                             full;
    logic [OCC_W-1:0]                 occupancy;

    logic [MEM_WORDS-1:0][XLEN-1:0]   mem;
    buffer_entry_t                    seen_q[$];
    int                               seed;

    tb_clock_gen u_clk (.clk_o(clk));

    fetch_buffer_top uut (
        .clk              (clk),
        .rst_i            (rst),
        .flush_i          (flush),
        .correct_pc_i     (correct_pc),
        .inst_addr_o      (inst_addr),
        .instr_i          (instr),
        .bp_update_i      (bp_update),
        .decode_entries_o (dec_entries),
        .decode_valid_o   (dec_valid),
        .decode_ready_i   (dec_ready),
        .buffer_empty_o   (empty),
        .buffer_full_o    (full),
        .occupancy_o      (occupancy)
    );

    bind fetch_buffer_top fetch_buffer_checker u_checker (
        .clk (clk), .rst_i (rst_i), .flush_i (flush_i), .correct_pc_i (correct_pc_i),
        .entries_i (decode_entries_o), .valid_i (decode_valid_o),
        .ready_i (decode_ready_i), .empty_i (buffer_empty_o), .full_i (buffer_full_o),
        .occ_i (occupancy_o), .mem_i (fetch_buffer_tb.mem)
    );

    // Memory answers in the same cycle, wraps on the word index
    always_comb begin
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            instr[k] = mem[inst_addr[k][MEM_IDX_W+1:2]];
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Run aborted");
    endtask

    // BEQ x0, x0 with a 13-bit offset
    function automatic logic [XLEN-1:0] encode_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $random(seed);
        end
        // Lead-in before the trained branch stays branch free
        mem[FLUSH_PC[MEM_IDX_W+1:2]]      = NOP;
        mem[FLUSH_PC[MEM_IDX_W+1:2] + 1]  = NOP;
        mem[BR_PC[MEM_IDX_W+1:2]]         = encode_branch(-13'sd32);
        // Second backward branch, left untrained
        mem[20]                           = encode_branch(-13'sd16);
    endtask

    // Drive ready on the falling edge, log what the next edge accepts
    task automatic step_cycle(input logic [FETCH_WIDTH-1:0] ready);
        logic chain;
        @(negedge clk);
        dec_ready = ready;
        chain     = 1'b1;
        for (int k = 0; k < FETCH_WIDTH; k++) begin
            chain = chain & dec_valid[k] & ready[k];
            if (chain)
                seen_q.push_back(dec_entries[k]);
        end
    endtask

    task automatic step_random();
        logic [31:0] rnd;
        rnd = $random(seed);
        step_cycle(rnd[FETCH_WIDTH-1:0]);
    endtask

    // Picks up any checker assertion at the next falling edge
    always @(negedge clk) begin
        if (uut.u_checker.fail_count != 0)
            fail_run("A checker assertion fired, see the error above");
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        fail_run("Watchdog expired before the stimulus finished");
    end

    initial begin
        int pos;
        int cycles;
        seed       = 7;
        rst        = 1'b1;
        flush      = 1'b0;
        correct_pc = '0;
        bp_update  = '0;
        dec_ready  = '0;
        fill_memory();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        ////////////////////////////////////////////////////////////
        // Free run, back-pressure, redirect
        ////////////////////////////////////////////////////////////

        repeat (WARM_CYCLES) step_random();
        // Decode stalled so the queue fills up
        repeat (FILL_CYCLES) step_cycle('0);
        // Single pops open room for one more group, queue reaches full
        repeat (TOPUP_CYCLES / 3) begin
            step_cycle(3'b001);
            repeat (2) step_cycle('0);
        end
        step_random();
        flush      = 1'b1;
        correct_pc = 32'h0000_0200;
        step_random();
        flush = 1'b0;
        repeat (WARM_CYCLES / 2) step_random();

        ////////////////////////////////////////////////////////////
        // Predictor training
        ////////////////////////////////////////////////////////////

        // Two taken outcomes take the counter from 1 to 3
        for (int n = 0; n < 2; n++) begin
            step_random();
            bp_update.valid = 1'b1;
            bp_update.pc    = BR_PC;
            bp_update.taken = 1'b1;
        end
        step_random();
        bp_update  = '0;
        flush      = 1'b1;
        correct_pc = FLUSH_PC;
        step_random();
        flush = 1'b0;
        seen_q.delete();

        // Wait for the branch and the entry after it
        pos    = -1;
        cycles = 0;
        while (cycles < TRAIN_LIMIT && !(pos >= 0 && seen_q.size() > pos + 1)) begin
            step_random();
            cycles++;
            foreach (seen_q[i]) begin
                if (pos < 0 && seen_q[i].pc == BR_PC)
                    pos = i;
            end
        end
        if (pos < 0)
            fail_run("Trained branch was never delivered after the flush");
        else if (seen_q.size() <= pos + 1)
            fail_run("No entry was delivered after the trained branch");
        else if (!seen_q[pos].pred)
            fail_run($sformatf("FAILED at %0t ns: branch at %h not predicted taken",
                               $time, BR_PC));
        else if (seen_q[pos + 1].pc != BR_TARGET)
            fail_run($sformatf("FAILED at %0t ns: after branch got PC %h, expected %h",
                               $time, seen_q[pos + 1].pc, BR_TARGET));

        repeat (TAIL_CYCLES) step_random();
        @(negedge clk);
        if (uut.u_checker.fail_count != 0) begin
            fail_run("A checker assertion fired, see the error above");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: flist.f
verilog/fetch_pkg.sv
verilog/branch_predictor.sv
verilog/multi_fetch.sv
verilog/instruction_buffer.sv
verilog/fetch_buffer_top.sv
test/tb_clock_gen.sv
test/fetch_buffer_checker.sv
test/fetch_buffer_tb.sv
